/* sim/patterns_cache.txt */
# kind(0 read, 1 write, 2 tlb write) addr wdata force_miss vmem mem_xfers dma_xfers fault value
# value is the expected read data, or for a write the physical address it must reach
0 00001234 00000000 0 0 2 0 0 5a5a1234
0 00001234 00000000 0 0 0 0 0 5a5a1234
0 00001235 00000000 0 0 0 0 0 5a5a1235
0 00001235 00000000 0 0 0 0 0 5a5a1235
1 00002040 cafe0001 0 0 1 0 0 00002040
0 00002040 00000000 0 0 0 0 0 cafe0001
0 00002041 00000000 0 0 2 0 0 5a5a2041
0 00002040 00000000 0 0 0 0 0 cafe0001
0 00001234 00000000 1 0 2 0 0 5a5a1234
0 00001234 00000000 0 0 0 0 0 5a5a1234
0 00011234 00000000 0 0 2 0 0 5a5b1234
0 00001234 00000000 0 0 2 0 0 5a5a1234
0 c0000010 00000000 0 0 0 2 0 9a5a0010
0 c0000011 00000000 0 0 0 0 0 9a5a0011
1 c0000020 0bad0020 0 0 0 1 0 c0000020
0 c0000020 00000000 0 0 0 0 0 0bad0020
0 c0000021 00000000 0 0 0 2 0 9a5a0021
0 80000050 00000000 0 0 2 0 0 da5a0050
1 40000060 12345678 0 0 1 0 0 40000060
0 40000060 00000000 1 0 2 0 0 12345678
2 00000300 00070012 0 1 0 0 0 00000000
0 00120344 00000000 0 1 2 0 0 5a5d0344
0 00120344 00000000 0 1 0 0 0 5a5d0344
0 00130344 00000000 0 1 0 0 1 00000000
0 00130500 00000000 0 1 0 0 1 00000000
2 00000500 c0010013 0 1 0 0 0 00000000
0 00130500 00000000 0 1 0 2 0 9a5b0500
1 00130504 feed0504 0 1 0 1 0 c0010504
0 00130504 00000000 0 1 0 0 0 feed0504
0 00120344 00000000 0 0 2 0 0 5a480344

/* verilog.f */
common/cache_pkg.sv
cache/cache_store.sv
cache/tlb_store.sv
cache/cache_ctrl.sv
design/mem_port.sv
design/snowball_cache_top.sv
sim/tb_snowball_cache.sv

/* Bender.yml */
package:
  name: snowball_cache

sources:
  - common/cache_pkg.sv
  - cache/cache_store.sv
  - cache/tlb_store.sv
  - cache/cache_ctrl.sv
  - design/mem_port.sv
  - design/snowball_cache_top.sv
  - target: test
    files:
      - sim/tb_snowball_cache.sv

/* sim/tb_snowball_cache.sv */
// testbench for the snowball cache top level
// clock, reset, pattern reader, memory and DMA four-phase responders
// compare tasks, protocol monitor and cycle-limit watchdog

`timescale 1ns/1ps

module tb_snowball_cache import cache_pkg::*; ();

  typedef struct {
    int    kind;       // 0 read, 1 write, 2 tlb write
    word_t addr;
    word_t wdata;
    logic  force_miss;
    logic  vmem;
    int    exp_mem;    // memory transfers expected
    int    exp_dma;    // dma transfers expected
    logic  exp_fault;
    word_t exp_val;    // read data, or physical write address
  } pattern_t;

  logic     CPU_CLK;
  logic     RST;
  cpu_req_t cpu_req;
  logic     vmem_act;
  cpu_rsp_t cpu_rsp;
  logic     busy;
  logic     mem_req;
  logic     mem_ack   = 1'b0;
  logic     mem_we;
  word_t    mem_addr;
  word_t    mem_wdata;
  word_t    mem_rdata = '0;
  logic     dma_req;
  logic     dma_we;
  logic     dma_ack   = 1'b0;
  word_t    dma_wdata;
  word_t    dma_rdata = '0;

  pattern_t pats[$];
  word_t    backing [word_t];
  word_t    last_wr_addr;
  word_t    last_wr_data;
  int       mem_wait    = 0;
  int       dma_wait    = 0;
  int       mem_xfers   = 0;
  int       dma_xfers   = 0;
  logic     mem_req_d   = 1'b0;
  logic     dma_req_d   = 1'b0;
  int       cycle_cnt   = 0;
  int       cycle_limit = 100000;
  int       ops_run     = 0;

  snowball_cache_top #(
    .TLB_EN_DEFAULT(1'b0)
  ) dut0 (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .cpu_req  (cpu_req),
    .vmem_act (vmem_act),
    .cpu_rsp  (cpu_rsp),
    .busy     (busy),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .dma_req  (dma_req),
    .dma_we   (dma_we),
    .dma_ack  (dma_ack),
    .dma_wdata(dma_wdata),
    .dma_rdata(dma_rdata)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #20 CPU_CLK = ~CPU_CLK;  // 40 ns period
  end

  // ----------------------------------------------------------------------
  // failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_rdata(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_fault(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s fault is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // backing store and four-phase responders
  // ----------------------------------------------------------------------
  function automatic word_t read_word(input word_t a);
    if (backing.exists(a))
      return backing[a];
    return a ^ 32'h5a5a0000;  // fill for unwritten words
  endfunction

  task automatic record_write(input word_t a, input word_t d);
    backing[a]   = d;
    last_wr_addr = a;
    last_wr_data = d;
  endtask

  always @(posedge CPU_CLK)
  begin
    if (!RST)
      mem_ack <= 1'b0;
    else if (mem_req && !mem_ack)
    begin
      if (mem_wait == 0)
      begin
        if (mem_we)
          record_write(mem_addr, mem_wdata);
        mem_rdata <= read_word(mem_addr);
        mem_ack   <= 1'b1;
      end
      else
        mem_wait <= mem_wait - 1;
    end
    else if (!mem_req && mem_ack)
    begin
      mem_ack  <= 1'b0;
      mem_wait <= $urandom_range(3, 0);  // delay of the next ack
    end
  end

  always @(posedge CPU_CLK)
  begin
    if (!RST)
      dma_ack <= 1'b0;
    else if (dma_req && !dma_ack)
    begin
      if (dma_wait == 0)
      begin
        if (dma_we)
          record_write(mem_addr, dma_wdata);  // dma shares the address bus
        dma_rdata <= read_word(mem_addr);
        dma_ack   <= 1'b1;
      end
      else
        dma_wait <= dma_wait - 1;
    end
    else if (!dma_req && dma_ack)
    begin
      dma_ack  <= 1'b0;
      dma_wait <= $urandom_range(3, 0);
    end
  end

  // handshake rules and transfer counting
  always @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      if (mem_req && dma_req)
      begin
        $display("ERROR: memory and DMA requests are high at the same time");
        abort_run();
      end
      if ((mem_req && !mem_req_d && mem_ack) || (dma_req && !dma_req_d && dma_ack))
      begin
        $display("ERROR: a request rose while its acknowledge was still high");
        abort_run();
      end
      if ((!mem_req && mem_req_d && !mem_ack) || (!dma_req && dma_req_d && !dma_ack))
      begin
        $display("ERROR: a request was dropped before it was acknowledged");
        abort_run();
      end
      if (mem_req && !mem_req_d)
        mem_xfers++;
      if (dma_req && !dma_req_d)
        dma_xfers++;
    end
    mem_req_d <= mem_req;
    dma_req_d <= dma_req;
  end

  always @(posedge CPU_CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("ERROR: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // pattern file and operation sequencing
  // ----------------------------------------------------------------------
  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [9];
    pattern_t    p;
    fd = $fopen("sim/patterns_cache.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open the pattern file sim/patterns_cache.txt");
      abort_run();
    end
    while ($fgets(line, fd))
    begin
      if (line.len() < 2 || line.substr(0, 0) == "#")
        continue;  // blank or column notes
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (n != 9)
      begin
        $display("ERROR: malformed pattern line: %s", line);
        abort_run();
      end
      p.kind       = f[0];
      p.addr       = f[1];
      p.wdata      = f[2];
      p.force_miss = f[3][0];
      p.vmem       = f[4][0];
      p.exp_mem    = f[5];
      p.exp_dma    = f[6];
      p.exp_fault  = f[7][0];
      p.exp_val    = f[8];
      pats.push_back(p);
    end
    $fclose(fd);
  endtask

  task automatic run_op(input pattern_t p);
    cpu_req_t req;
    int       cyc;
    logic     busy_t1;
    string    tag;
    tag = $sformatf("op %0d at %h", ops_run, p.addr);
    @(posedge CPU_CLK);
    while (busy)
      @(posedge CPU_CLK);
    mem_xfers      = 0;
    dma_xfers      = 0;
    req.valid      = 1'b1;
    req.we         = (p.kind == 1);
    req.tlb_we     = (p.kind == 2);
    req.force_miss = p.force_miss;
    req.addr       = p.addr;
    req.wdata      = p.wdata;
    cpu_req  <= req;
    vmem_act <= p.vmem;
    @(posedge CPU_CLK);  // accepted here
    cpu_req.valid <= 1'b0;
    @(negedge CPU_CLK);
    busy_t1 = busy;
    if (p.kind == 2)
      check_flag(busy_t1, 1'b0, {tag, " busy after tlb write"});
    else if (p.kind == 1)
    begin
      check_flag(busy_t1, 1'b1, {tag, " busy after write"});
      while (busy)
        @(negedge CPU_CLK);
      check_rdata(last_wr_addr, p.exp_val, {tag, " backing write address"});
      check_rdata(last_wr_data, p.wdata, {tag, " backing write data"});
    end
    else
    begin
      cyc = 1;
      while (!cpu_rsp.rd_valid)
      begin
        @(negedge CPU_CLK);
        cyc++;
      end
      if (p.exp_mem + p.exp_dma == 0)
      begin
        check_flag(busy_t1, 1'b0, {tag, " busy on hit or fault"});
        check_count(cyc, 2, {tag, " cycles to rd_valid"});
      end
      else
        check_flag(busy_t1, 1'b1, {tag, " busy on miss"});
      check_flag(busy, 1'b0, {tag, " busy with rd_valid"});
      check_fault(cpu_rsp.fault, p.exp_fault, tag);
      if (!p.exp_fault)
        check_rdata(cpu_rsp.rdata, p.exp_val, {tag, " read data"});
    end
    check_count(mem_xfers, p.exp_mem, {tag, " memory transfers"});
    check_count(dma_xfers, p.exp_dma, {tag, " DMA transfers"});
    ops_run++;
  endtask

  initial
  begin
    void'($urandom(32'h62b9b8f6));
    RST      = 1'b0;
    cpu_req  = '0;
    vmem_act = 1'b0;
    load_patterns();
    cycle_limit = 40 * pats.size() + 20;  // 40 cycles per line plus reset
    repeat (5) @(posedge CPU_CLK);
    RST <= 1'b1;
    @(negedge CPU_CLK);
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(mem_req, 1'b0, "mem_req after reset");
    check_flag(dma_req, 1'b0, "dma_req after reset");
    check_flag(cpu_rsp.rd_valid, 1'b0, "rd_valid after reset");
    check_fault(cpu_rsp.fault, 1'b0, "reset");
    foreach (pats[i])
      run_op(pats[i]);
    repeat (2) @(posedge CPU_CLK);
    if (pats.size() > 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("ERROR: the pattern file holds no operations");
      abort_run();
    end
  end

endmodule

/* design/snowball_cache_top.sv */
// top level of the snowball cache
// controller, cache arrays, tlb arrays and backing port

`timescale 1ns/1ps

module snowball_cache_top import cache_pkg::*; #(
  parameter bit TLB_EN_DEFAULT = 1'b0
) (
  input  logic     CPU_CLK,
  input  logic     RST,
  input  cpu_req_t cpu_req,
  input  logic     vmem_act,
  output cpu_rsp_t cpu_rsp,
  output logic     busy,
  output logic     mem_req,
  input  logic     mem_ack,
  output logic     mem_we,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  input  word_t    mem_rdata,
  output logic     dma_req,
  output logic     dma_we,
  input  logic     dma_ack,
  output word_t    dma_wdata,
  input  word_t    dma_rdata
);

  idx_t      st_rd_idx;
  ctag_t     st_rd_tag;
  word_t     st_rd_data;
  logic      st_rd_valid;
  logic      st_wr_en;
  idx_t      st_wr_idx;
  ctag_t     st_wr_tag;
  word_t     st_wr_data;
  tlb_idx_t  tlb_lk_idx;
  page_t     tlb_lk_vpage;
  logic      tlb_vmem;
  page_t     tlb_phys_page;
  logic      tlb_fault;
  logic      tlb_wr_en;
  tlb_idx_t  tlb_wr_idx;
  word_t     tlb_wr_entry;
  mem_op_t   mem_op;
  mem_done_t mem_done;

  assign dma_wdata = mem_wdata;  // one write bus for both targets

  cache_ctrl #(
    .TLB_EN_DEFAULT(TLB_EN_DEFAULT)
  ) ctrl0 (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .cpu_req      (cpu_req),
    .vmem_act     (vmem_act),
    .cpu_rsp      (cpu_rsp),
    .busy         (busy),
    .st_rd_idx    (st_rd_idx),
    .st_rd_tag    (st_rd_tag),
    .st_rd_data   (st_rd_data),
    .st_rd_valid  (st_rd_valid),
    .st_wr_en     (st_wr_en),
    .st_wr_idx    (st_wr_idx),
    .st_wr_tag    (st_wr_tag),
    .st_wr_data   (st_wr_data),
    .tlb_lk_idx   (tlb_lk_idx),
    .tlb_lk_vpage (tlb_lk_vpage),
    .tlb_vmem     (tlb_vmem),
    .tlb_phys_page(tlb_phys_page),
    .tlb_fault    (tlb_fault),
    .tlb_wr_en    (tlb_wr_en),
    .tlb_wr_idx   (tlb_wr_idx),
    .tlb_wr_entry (tlb_wr_entry),
    .mem_op       (mem_op),
    .mem_done     (mem_done)
  );

  cache_store store0 (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .rd_idx      (st_rd_idx),
    .rd_tag      (st_rd_tag),
    .rd_data     (st_rd_data),
    .rd_hit_valid(st_rd_valid),
    .wr_en       (st_wr_en),
    .wr_idx      (st_wr_idx),
    .wr_tag      (st_wr_tag),
    .wr_data     (st_wr_data)
  );

  tlb_store tlb0 (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .lk_idx   (tlb_lk_idx),
    .lk_vpage (tlb_lk_vpage),
    .vmem     (tlb_vmem),
    .phys_page(tlb_phys_page),
    .fault    (tlb_fault),
    .wr_en    (tlb_wr_en),
    .wr_idx   (tlb_wr_idx),
    .wr_entry (tlb_wr_entry)
  );

  mem_port port0 (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .mem_op   (mem_op),
    .mem_done (mem_done),
    .mem_req  (mem_req),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_ack  (mem_ack),
    .mem_rdata(mem_rdata),
    .dma_req  (dma_req),
    .dma_we   (dma_we),
    .dma_ack  (dma_ack),
    .dma_rdata(dma_rdata)
  );

endmodule

/* design/mem_port.sv */
// backing-side port of the cache
// target select from physical address bits 31:30
// four-phase req/ack engine shared by memory and DMA
// second transfer for the pair partner on a refill

`timescale 1ns/1ps

module mem_port import cache_pkg::*; (
  input  logic      CPU_CLK,
  input  logic      RST,
  input  mem_op_t   mem_op,
  output mem_done_t mem_done,
  output logic      mem_req,
  output logic      mem_we,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  input  logic      mem_ack,
  input  word_t     mem_rdata,
  output logic      dma_req,
  output logic      dma_we,
  input  logic      dma_ack,
  input  word_t     dma_rdata
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_REQ,   // req high, waiting for ack
    P_REL,   // req low, waiting for ack to drop
    P_DONE
  } port_state_e;

  port_state_e pstate;
  target_e     tgt_q;
  logic        req_q;
  logic        second_q;
  logic        we_q;
  logic        refill_q;
  logic        ack;
  logic        start;
  logic        next_word;
  word_t       rdata;
  word_t       first_q;
  word_t       pair_q;

  assign ack   = (tgt_q == TGT_DMA) ? dma_ack : mem_ack;
  assign rdata = (tgt_q == TGT_DMA) ? dma_rdata : mem_rdata;

  assign start     = (pstate == P_IDLE) && mem_op.valid;
  assign next_word = (pstate == P_REL) && !ack && refill_q && !second_q;

  assign mem_req = req_q && (tgt_q == TGT_MEM);
  assign dma_req = req_q && (tgt_q == TGT_DMA);
  assign mem_we  = mem_req && we_q;
  assign dma_we  = dma_req && we_q;

  assign mem_done = '{done: (pstate == P_DONE), first_data: first_q, pair_data: pair_q};

  // ----------------------------------------------------------------------
  // handshake sequencing
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      pstate   <= P_IDLE;
      req_q    <= 1'b0;
      second_q <= 1'b0;
    end
    else
    begin
      case (pstate)
        P_IDLE:
          if (start)
          begin
            req_q    <= 1'b1;
            second_q <= 1'b0;
            pstate   <= P_REQ;
          end
        P_REQ:
          if (ack)
          begin
            req_q  <= 1'b0;
            pstate <= P_REL;
          end
        P_REL:
          if (next_word)
          begin
            req_q    <= 1'b1;   // partner word right away
            second_q <= 1'b1;
            pstate   <= P_REQ;
          end
          else if (!ack)
            pstate <= P_DONE;
        default:
          pstate <= P_IDLE;     // done pulse lasts one cycle
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      tgt_q     <= (mem_op.addr[31:30] == DMA_SEL) ? TGT_DMA : TGT_MEM;
      we_q      <= mem_op.we;
      refill_q  <= mem_op.refill;
      mem_addr  <= mem_op.addr;
      mem_wdata <= mem_op.wdata;
    end
    else if (next_word)
      mem_addr[0] <= ~mem_addr[0];  // pair partner
    if ((pstate == P_REQ) && ack)
    begin
      if (second_q)
        pair_q <= rdata;
      else
        first_q <= rdata;
    end
  end

  a_req_after_ack: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(req_q) |-> !ack)
    else $error("request raised while the previous ack is still high");

endmodule

/* cache/cache_ctrl.sv */
// cache controller
// request capture, translated tag compare and hit test
// response register and busy generation
// miss / write-through job sequencing and pair write-back into the store

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
  parameter bit TLB_EN_DEFAULT = 1'b0
) (
  input  logic      CPU_CLK,
  input  logic      RST,
  input  cpu_req_t  cpu_req,
  input  logic      vmem_act,
  output cpu_rsp_t  cpu_rsp,
  output logic      busy,
  output idx_t      st_rd_idx,
  input  ctag_t     st_rd_tag,
  input  word_t     st_rd_data,
  input  logic      st_rd_valid,
  output logic      st_wr_en,
  output idx_t      st_wr_idx,
  output ctag_t     st_wr_tag,
  output word_t     st_wr_data,
  output tlb_idx_t  tlb_lk_idx,
  output page_t     tlb_lk_vpage,
  output logic      tlb_vmem,
  input  page_t     tlb_phys_page,
  input  logic      tlb_fault,
  output logic      tlb_wr_en,
  output tlb_idx_t  tlb_wr_idx,
  output word_t     tlb_wr_entry,
  output mem_op_t   mem_op,
  input  mem_done_t mem_done
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  cpu_req_t    req_q;
  mem_op_t     op_q;
  logic        op_valid_q;
  logic        vmem;
  logic        rsp_valid_q;
  logic        rsp_fault_q;
  word_t       rsp_data_q;
  word_t       pair_q;
  word_t       phys_addr;
  logic        hit;
  logic        need_mem;
  logic        accept;

  // ----------------------------------------------------------------------
  // lookup side, arrays are addressed straight from the request
  // ----------------------------------------------------------------------
  assign st_rd_idx    = cpu_req.addr[7:0];
  assign tlb_lk_idx   = cpu_req.addr[15:8];
  assign tlb_lk_vpage = req_q.addr[31:16];
  assign tlb_vmem     = vmem;

  assign tlb_wr_en    = cpu_req.valid && cpu_req.tlb_we && !busy;  // no busy for tlb writes
  assign tlb_wr_idx   = cpu_req.addr[15:8];
  assign tlb_wr_entry = cpu_req.wdata;

  assign phys_addr = {tlb_phys_page, req_q.addr[15:0]};
  assign hit       = st_rd_valid && (st_rd_tag == phys_addr[31:8]);
  assign need_mem  = !tlb_fault && (req_q.we || req_q.force_miss || !hit);

  assign busy   = ((state == LOOKUP) && need_mem) || (state == WAIT_MEM);
  assign accept = cpu_req.valid && !cpu_req.tlb_we && !busy;

  assign cpu_rsp = '{rd_valid: rsp_valid_q, rdata: rsp_data_q, fault: rsp_fault_q};
  assign mem_op  = '{valid: op_valid_q, we: op_q.we, refill: op_q.refill,
                     addr: op_q.addr, wdata: op_q.wdata};

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (accept)
          state_nxt = LOOKUP;
      LOOKUP:
        if (need_mem)
          state_nxt = WAIT_MEM;
        else if (!accept)
          state_nxt = IDLE;     // hits may chain back to back
      WAIT_MEM:
        if (mem_done.done)
          state_nxt = RESPOND;
      RESPOND:
        state_nxt = accept ? LOOKUP : IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state       <= IDLE;
      vmem        <= TLB_EN_DEFAULT;
      rsp_valid_q <= 1'b0;
      rsp_fault_q <= 1'b0;
      op_valid_q  <= 1'b0;
    end
    else
    begin
      state       <= state_nxt;
      vmem        <= vmem_act;
      rsp_valid_q <= ((state == LOOKUP) && !need_mem) ||
                     ((state == WAIT_MEM) && mem_done.done && !op_q.we);
      rsp_fault_q <= (state == LOOKUP) && tlb_fault;
      if ((state == LOOKUP) && need_mem)
        op_valid_q <= 1'b1;
      else if (mem_done.done)
        op_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
      req_q <= cpu_req;
    if ((state == LOOKUP) && need_mem)
    begin
      op_q.we     <= req_q.we;
      op_q.refill <= !req_q.we;  // every read miss pulls the pair
      op_q.addr   <= phys_addr;
      op_q.wdata  <= req_q.wdata;
    end
    if (state == LOOKUP)
      rsp_data_q <= tlb_fault ? '0 : st_rd_data;
    else if ((state == WAIT_MEM) && mem_done.done)
    begin
      rsp_data_q <= mem_done.first_data;
      pair_q     <= mem_done.pair_data;
    end
  end

  // ----------------------------------------------------------------------
  // store update, requested word on done and partner word one cycle later
  // ----------------------------------------------------------------------
  always_comb
  begin
    st_wr_en   = 1'b0;
    st_wr_idx  = op_q.addr[7:0];
    st_wr_tag  = op_q.addr[31:8];
    st_wr_data = op_q.we ? op_q.wdata : mem_done.first_data;
    if ((state == WAIT_MEM) && mem_done.done)
      st_wr_en = 1'b1;
    else if ((state == RESPOND) && op_q.refill)
    begin
      st_wr_en   = 1'b1;
      st_wr_idx  = {op_q.addr[7:1], ~op_q.addr[0]};
      st_wr_data = pair_q;
    end
  end

  a_no_req_busy: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cpu_req.valid |-> !busy)
    else $error("CPU request offered while cache busy");

  a_op_stable: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_op.valid && !mem_done.done |=> mem_op.valid && $stable(mem_op))
    else $error("memory job changed before done");

endmodule

/* cache/tlb_store.sv */
// translation arrays, physical and virtual tag halves
// synchronous lookup with per-entry valid bits
// physical page select and fault detection

`timescale 1ns/1ps

module tlb_store import cache_pkg::*; (
  input  logic     CPU_CLK,
  input  logic     RST,
  input  tlb_idx_t lk_idx,
  input  page_t    lk_vpage,
  input  logic     vmem,
  output page_t    phys_page,
  output logic     fault,
  input  logic     wr_en,
  input  tlb_idx_t wr_idx,
  input  word_t    wr_entry
);

  page_t                phys_mem [TLB_DEPTH];
  page_t                vtag_mem [TLB_DEPTH];
  logic [TLB_DEPTH-1:0] valid_q;
  logic                 vld_rd;
  page_t                phys_rd;
  page_t                vtag_rd;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid_q <= '0;
      vld_rd  <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid_q[wr_idx] <= 1'b1;
      vld_rd <= valid_q[lk_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      phys_mem[wr_idx] <= wr_entry[31:16];  // upper half is the physical page
      vtag_mem[wr_idx] <= wr_entry[15:0];   // lower half is the virtual tag
    end
    phys_rd <= phys_mem[lk_idx];
    vtag_rd <= vtag_mem[lk_idx];
  end

  // ----------------------------------------------------------------------
  // translation result, one cycle after lk_idx
  // ----------------------------------------------------------------------
  assign phys_page = vmem ? phys_rd : lk_vpage;  // identity map when off

  // an empty entry faults like a wrong tag
  assign fault = vmem && (!vld_rd || (vtag_rd != lk_vpage));

endmodule

/* cache/cache_store.sv */
// direct-mapped tag and data arrays
// synchronous read port with write-first forwarding
// per-entry valid bits cleared by reset

`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
  input  logic  CPU_CLK,
  input  logic  RST,
  input  idx_t  rd_idx,
  output ctag_t rd_tag,
  output word_t rd_data,
  output logic  rd_hit_valid,
  input  logic  wr_en,
  input  idx_t  wr_idx,
  input  ctag_t wr_tag,
  input  word_t wr_data
);

  ctag_t                  tag_mem  [CACHE_DEPTH];
  word_t                  data_mem [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid_q;
  logic                   fwd;

  // same-cycle write to the read index wins
  assign fwd = wr_en && (wr_idx == rd_idx);

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid_q      <= '0;    // whole vector in one cycle
      rd_hit_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid_q[wr_idx] <= 1'b1;
      rd_hit_valid <= fwd || valid_q[rd_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= wr_data;
    end
    rd_tag  <= fwd ? wr_tag : tag_mem[rd_idx];
    rd_data <= fwd ? wr_data : data_mem[rd_idx];
  end

  a_wr_idx_known: assert property (@(posedge CPU_CLK) disable iff (!RST)
    wr_en |-> !$isunknown(wr_idx))
    else $error("cache write with unknown index");

endmodule

/* common/cache_pkg.sv */
// shared types for the snowball cache
// address fields, cache tag and array depths
// CPU request and response structs
// memory job and completion structs
// controller state and backing target enums

package cache_pkg;

  // ----------------------------------------------------------------------
  // address fields
  // ----------------------------------------------------------------------
  typedef logic [31:0] word_t;     // data word and address
  typedef logic [7:0]  idx_t;      // cache index, addr[7:0]
  typedef logic [7:0]  tlb_idx_t;  // tlb index, addr[15:8]
  typedef logic [15:0] page_t;     // page, addr[31:16]
  typedef logic [23:0] ctag_t;     // physical page + tlb index field

  localparam int CACHE_DEPTH = 2 ** $bits(idx_t);
  localparam int TLB_DEPTH   = 2 ** $bits(tlb_idx_t);

  localparam logic [1:0] DMA_SEL = 2'b11;  // phys[31:30] for the dma port

  // ----------------------------------------------------------------------
  // CPU side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  valid;       // one-cycle strobe
    logic  we;
    logic  tlb_we;      // write a tlb entry from wdata
    logic  force_miss;  // read around the cache
    word_t addr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  rd_valid;
    word_t rdata;
    logic  fault;
  } cpu_rsp_t;

  // ----------------------------------------------------------------------
  // controller to memory port
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  valid;   // level, held until done
    logic  we;
    logic  refill;  // read both words of the pair
    word_t addr;    // physical
    word_t wdata;
  } mem_op_t;

  typedef struct packed {
    logic  done;        // one-cycle pulse
    word_t first_data;  // requested word
    word_t pair_data;   // partner word of a refill
  } mem_done_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_MEM,
    RESPOND
  } ctrl_state_e;

  typedef enum logic {
    TGT_MEM,
    TGT_DMA
  } target_e;

endpackage
